/* link_defs.svh */
// Link defaults for beat width and FIFO depth
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// ------------------------------
// Data path
// ------------------------------

// Width of one data beat on the link
`define LINK_DATA_W 32

// ------------------------------
// Buffering
// ------------------------------

// log2 of the FIFO depth, 16 entries
`define LINK_FIFO_AW 4

`endif

/* link_pkg.sv */
// Link package with beat structs and direction state
`include "link_defs.svh"

package link_pkg;

    // ------------------------------
    // Beats
    // ------------------------------

    // Inbound beat, tag set steers it to ccu
    typedef struct packed {
        logic [`LINK_DATA_W-1:0] data;
        logic                    last;
        logic                    tag;
    } in_beat_t;

    // Outbound beat with command flag
    typedef struct packed {
        logic [`LINK_DATA_W-1:0] data;
        logic                    cmd;
        logic                    last;
    } out_beat_t;

    // ------------------------------
    // Direction
    // ------------------------------

    typedef enum logic [1:0] {
        DIR_IDLE = 2'd0,
        DIR_IN   = 2'd1,
        DIR_OUT  = 2'd2
    } link_dir_t;

endpackage

/* beat_fifo.sv */
// Beat FIFO, synchronous first-word-fall-through buffer for one payload type
`include "link_defs.svh"

module beat_fifo
    import link_pkg::*;
#(
    parameter type beat_t = in_beat_t,
    parameter int  ADDR_W = `LINK_FIFO_AW
) (
    input  logic  clk,
    input  logic  rst_n,

    // Write side
    input  logic  push_i,
    input  beat_t push_beat_i,
    output logic  full_o,

    // Read side
    input  logic  pop_i,
    output beat_t head_o,
    output logic  empty_o
);

    localparam int DEPTH = 1 << ADDR_W;

    beat_t             mem [DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              wr_en;
    logic              rd_en;

    // ------------------------------
    // Status
    // ------------------------------

    // Extra pointer bit tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_en = push_i && !full_o;
    assign rd_en = pop_i && !empty_o;

    // Head shows the oldest entry straight away
    assign head_o = mem[rd_ptr[ADDR_W-1:0]];

    // ------------------------------
    // Storage and pointers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_beat_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Producer must respect full, consumer must respect empty
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n) !(push_i && full_o)
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n) !(pop_i && empty_o)
    );

endmodule

/* link_dir_fsm.sv */
// Direction FSM, grants the link to one inbound or outbound burst at a time
`include "link_defs.svh"

module link_dir_fsm
    import link_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Burst requests
    input  logic      off_in_vld_i,
    input  logic      mon_vld_i,
    input  logic      gic_vld_i,

    // Burst completion
    input  logic      in_last_done_i,
    input  logic      out_last_done_i,

    output link_dir_t dir_o
);

    link_dir_t state_q;
    link_dir_t state_d;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            DIR_IDLE: begin
                // Inbound wins a tie with on-chip requests
                if (off_in_vld_i) begin
                    state_d = DIR_IN;
                end else if (mon_vld_i || gic_vld_i) begin
                    state_d = DIR_OUT;
                end
            end
            DIR_IN: begin
                if (in_last_done_i) begin
                    state_d = DIR_IDLE;
                end
            end
            DIR_OUT: begin
                if (out_last_done_i) begin
                    state_d = DIR_IDLE;
                end
            end
            default: begin
                state_d = DIR_IDLE;
            end
        endcase
    end

    // ------------------------------
    // State register
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign dir_o = state_q;

    a_state_legal : assert property (
        @(posedge clk) disable iff (!rst_n) state_q inside {DIR_IDLE, DIR_IN, DIR_OUT}
    );

endmodule

/* link_port.sv */
// Off-chip port that takes inbound beats into the FIFO and drives outbound beats
`include "link_defs.svh"

module link_port
    import link_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  link_dir_t dir_i,

    // Off-chip inbound
    input  logic      off_in_vld_i,
    input  in_beat_t  off_in_beat_i,
    output logic      off_in_rdy_o,

    // Inbound FIFO write side
    output logic      in_push_o,
    output in_beat_t  in_push_beat_o,
    input  logic      in_full_i,

    // Outbound FIFO read side
    input  out_beat_t out_head_i,
    input  logic      out_empty_i,
    output logic      out_pop_o,

    // Off-chip outbound
    output logic      off_out_vld_o,
    output out_beat_t off_out_beat_o,
    input  logic      off_out_rdy_i,
    output logic      oe_o,

    output logic      out_last_done_o
);

    logic in_done_q;
    logic in_open;

    // ------------------------------
    // Inbound
    // ------------------------------

    // Stop taking beats once the last one is in
    assign in_open        = (dir_i == DIR_IN) && !in_done_q;
    assign off_in_rdy_o   = in_open && !in_full_i;
    assign in_push_o      = off_in_vld_i && off_in_rdy_o;
    assign in_push_beat_o = off_in_beat_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_done_q <= 1'b0;
        end else if (dir_i != DIR_IN) begin
            in_done_q <= 1'b0;
        end else if (in_push_o && off_in_beat_i.last) begin
            in_done_q <= 1'b1;
        end
    end

    // ------------------------------
    // Outbound
    // ------------------------------

    // Bus is driven only while outbound
    assign oe_o            = (dir_i == DIR_OUT);
    assign off_out_vld_o   = oe_o && !out_empty_i;
    assign off_out_beat_o  = oe_o ? out_head_i : '0;
    assign out_pop_o       = off_out_vld_o && off_out_rdy_i;
    assign out_last_done_o = out_pop_o && out_head_i.last;

    a_oe_excl_rdy : assert property (
        @(posedge clk) disable iff (!rst_n) !(oe_o && off_in_rdy_o)
    );

endmodule

/* inbound_router.sv */
// Inbound router, steers the FIFO head to ccu or gic by its tag
`include "link_defs.svh"

module inbound_router
    import link_pkg::*;
(
    // Inbound FIFO read side
    input  in_beat_t                in_head_i,
    input  logic                    in_empty_i,
    output logic                    in_pop_o,

    // Instruction port
    output logic                    ccu_vld_o,
    output logic [`LINK_DATA_W-1:0] ccu_data_o,
    output logic                    ccu_last_o,
    input  logic                    ccu_rdy_i,

    // Buffer-controller port
    output logic                    gic_vld_o,
    output logic [`LINK_DATA_W-1:0] gic_data_o,
    output logic                    gic_last_o,
    input  logic                    gic_rdy_i,

    output logic                    in_last_done_o
);

    logic ccu_hs;
    logic gic_hs;

    // Tag picks the target
    assign ccu_vld_o  = !in_empty_i && in_head_i.tag;
    assign gic_vld_o  = !in_empty_i && !in_head_i.tag;

    assign ccu_data_o = in_head_i.data;
    assign ccu_last_o = in_head_i.last;
    assign gic_data_o = in_head_i.data;
    assign gic_last_o = in_head_i.last;

    // Pop on the chosen handshake only
    assign ccu_hs   = ccu_vld_o && ccu_rdy_i;
    assign gic_hs   = gic_vld_o && gic_rdy_i;
    assign in_pop_o = ccu_hs || gic_hs;

    assign in_last_done_o = in_pop_o && in_head_i.last;

endmodule

/* outbound_merger.sv */
// Outbound merger, locks the monitor or gic source per burst and fills the FIFO
`include "link_defs.svh"

module outbound_merger
    import link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  link_dir_t               dir_i,

    // Monitor source
    input  logic                    mon_vld_i,
    input  logic [`LINK_DATA_W-1:0] mon_data_i,
    input  logic                    mon_last_i,
    output logic                    mon_rdy_o,

    // Buffer-controller source
    input  logic                    gic_vld_i,
    input  out_beat_t               gic_beat_i,
    output logic                    gic_rdy_o,

    // Outbound FIFO write side
    output logic                    out_push_o,
    output out_beat_t               out_push_beat_o,
    input  logic                    out_full_i
);

    logic locked_q;
    logic src_mon_q;
    logic done_q;
    logic active;
    logic sel_mon;

    // ------------------------------
    // Source select
    // ------------------------------

    // First outbound cycle picks by mon_vld_i, later cycles use the lock
    assign sel_mon = locked_q ? src_mon_q : mon_vld_i;
    assign active  = (dir_i == DIR_OUT) && !done_q;

    assign mon_rdy_o  = active && sel_mon && !out_full_i;
    assign gic_rdy_o  = active && !sel_mon && !out_full_i;
    assign out_push_o = (mon_vld_i && mon_rdy_o) || (gic_vld_i && gic_rdy_o);

    always_comb begin
        out_push_beat_o = gic_beat_i;
        if (sel_mon) begin
            out_push_beat_o.data = mon_data_i;
            out_push_beat_o.cmd  = 1'b0;
            out_push_beat_o.last = mon_last_i;
        end
    end

    // ------------------------------
    // Burst tracking
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked_q  <= 1'b0;
            src_mon_q <= 1'b0;
            done_q    <= 1'b0;
        end else if (dir_i != DIR_OUT) begin
            locked_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (!locked_q) begin
                locked_q  <= 1'b1;
                src_mon_q <= mon_vld_i;
            end
            // Hold off until the state leaves outbound
            if (out_push_o && out_push_beat_o.last) begin
                done_q <= 1'b1;
            end
        end
    end

endmodule

/* chip_link_top.sv */
// Chip link top, half-duplex off-chip link with direction FSM and beat FIFOs
`include "link_defs.svh"

module chip_link_top
    import link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Off-chip inbound
    input  logic                    off_in_vld_i,
    input  in_beat_t                off_in_beat_i,
    output logic                    off_in_rdy_o,

    // Off-chip outbound
    output logic                    off_out_vld_o,
    output out_beat_t               off_out_beat_o,
    input  logic                    off_out_rdy_i,
    output logic                    oe_o,

    // Instruction port
    output logic                    ccu_vld_o,
    output logic [`LINK_DATA_W-1:0] ccu_data_o,
    output logic                    ccu_last_o,
    input  logic                    ccu_rdy_i,

    // Buffer controller, inbound side
    output logic                    gic_vld_o,
    output logic [`LINK_DATA_W-1:0] gic_data_o,
    output logic                    gic_last_o,
    input  logic                    gic_rdy_i,

    // Buffer controller, outbound side
    input  logic                    gic_vld_i,
    input  out_beat_t               gic_beat_i,
    output logic                    gic_rdy_o,

    // Monitor
    input  logic                    mon_vld_i,
    input  logic [`LINK_DATA_W-1:0] mon_data_i,
    input  logic                    mon_last_i,
    output logic                    mon_rdy_o
);

    link_dir_t dir;

    logic      in_push;
    in_beat_t  in_push_beat;
    logic      in_full;
    logic      in_pop;
    in_beat_t  in_head;
    logic      in_empty;
    logic      in_last_done;

    logic      out_push;
    out_beat_t out_push_beat;
    logic      out_full;
    logic      out_pop;
    out_beat_t out_head;
    logic      out_empty;
    logic      out_last_done;

    // ------------------------------
    // Control
    // ------------------------------

    link_dir_fsm u_dir_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .off_in_vld_i    (off_in_vld_i),
        .mon_vld_i       (mon_vld_i),
        .gic_vld_i       (gic_vld_i),
        .in_last_done_i  (in_last_done),
        .out_last_done_i (out_last_done),
        .dir_o           (dir)
    );

    // ------------------------------
    // Producers
    // ------------------------------

    link_port u_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .dir_i           (dir),
        .off_in_vld_i    (off_in_vld_i),
        .off_in_beat_i   (off_in_beat_i),
        .off_in_rdy_o    (off_in_rdy_o),
        .in_push_o       (in_push),
        .in_push_beat_o  (in_push_beat),
        .in_full_i       (in_full),
        .out_head_i      (out_head),
        .out_empty_i     (out_empty),
        .out_pop_o       (out_pop),
        .off_out_vld_o   (off_out_vld_o),
        .off_out_beat_o  (off_out_beat_o),
        .off_out_rdy_i   (off_out_rdy_i),
        .oe_o            (oe_o),
        .out_last_done_o (out_last_done)
    );

    outbound_merger u_merger (
        .clk             (clk),
        .rst_n           (rst_n),
        .dir_i           (dir),
        .mon_vld_i       (mon_vld_i),
        .mon_data_i      (mon_data_i),
        .mon_last_i      (mon_last_i),
        .mon_rdy_o       (mon_rdy_o),
        .gic_vld_i       (gic_vld_i),
        .gic_beat_i      (gic_beat_i),
        .gic_rdy_o       (gic_rdy_o),
        .out_push_o      (out_push),
        .out_push_beat_o (out_push_beat),
        .out_full_i      (out_full)
    );

    // ------------------------------
    // Buffers
    // ------------------------------

    beat_fifo #(
        .beat_t (in_beat_t),
        .ADDR_W (`LINK_FIFO_AW)
    ) u_in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (in_push),
        .push_beat_i (in_push_beat),
        .full_o      (in_full),
        .pop_i       (in_pop),
        .head_o      (in_head),
        .empty_o     (in_empty)
    );

    beat_fifo #(
        .beat_t (out_beat_t),
        .ADDR_W (`LINK_FIFO_AW)
    ) u_out_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (out_push),
        .push_beat_i (out_push_beat),
        .full_o      (out_full),
        .pop_i       (out_pop),
        .head_o      (out_head),
        .empty_o     (out_empty)
    );

    // ------------------------------
    // Consumer
    // ------------------------------

    inbound_router u_router (
        .in_head_i      (in_head),
        .in_empty_i     (in_empty),
        .in_pop_o       (in_pop),
        .ccu_vld_o      (ccu_vld_o),
        .ccu_data_o     (ccu_data_o),
        .ccu_last_o     (ccu_last_o),
        .ccu_rdy_i      (ccu_rdy_i),
        .gic_vld_o      (gic_vld_o),
        .gic_data_o     (gic_data_o),
        .gic_last_o     (gic_last_o),
        .gic_rdy_i      (gic_rdy_i),
        .in_last_done_o (in_last_done)
    );

endmodule

/* link_checker.sv */
// Link checker, compares routed and off-chip beats against expected queues
`include "link_defs.svh"

module link_checker
    import link_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,

    // Off-chip side
    input logic                    off_in_rdy_i,
    input logic                    off_out_vld_i,
    input out_beat_t               off_out_beat_i,
    input logic                    off_out_rdy_i,
    input logic                    oe_i,

    // On-chip side
    input logic                    ccu_vld_i,
    input logic [`LINK_DATA_W-1:0] ccu_data_i,
    input logic                    ccu_last_i,
    input logic                    ccu_rdy_i,
    input logic                    gic_in_vld_i,
    input logic [`LINK_DATA_W-1:0] gic_in_data_i,
    input logic                    gic_in_last_i,
    input logic                    gic_in_rdy_i,
    input logic                    gic_out_rdy_i,
    input logic                    mon_rdy_i
);

    // Inbound entries are {data, last}
    logic [`LINK_DATA_W:0] ccu_exp_q [$];
    logic [`LINK_DATA_W:0] gic_exp_q [$];
    out_beat_t             off_exp_q [$];
    logic [`LINK_DATA_W:0] exp_in;
    out_beat_t             exp_out;
    int                    data_errs = 0;
    int                    proto_errs = 0;

    // ------------------------------
    // Queue access for the drivers
    // ------------------------------

    task automatic expect_in(input logic to_gic, input logic [`LINK_DATA_W-1:0] data,
                             input logic last);
        if (to_gic) begin
            gic_exp_q.push_back({data, last});
        end else begin
            ccu_exp_q.push_back({data, last});
        end
    endtask

    task automatic queue_out_beat(input out_beat_t beat);
        off_exp_q.push_back(beat);
    endtask

    function automatic int pending();
        return ccu_exp_q.size() + gic_exp_q.size() + off_exp_q.size();
    endfunction

    task automatic compare(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            data_errs++;
            $display("Fail %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic protocol_error(input string what);
        proto_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic report_leftover();
        if (pending() != 0) begin
            protocol_error($sformatf("%0d expected beats never arrived", pending()));
        end
    endtask

    // ------------------------------
    // Sampling
    // ------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            // Everything quiet while in reset
            compare("oe_o", 0, oe_i);
            compare("off_in_rdy_o", 0, off_in_rdy_i);
            compare("off_out_vld_o", 0, off_out_vld_i);
            compare("ccu_vld_o", 0, ccu_vld_i);
            compare("gic_vld_o", 0, gic_in_vld_i);
            compare("gic_rdy_o", 0, gic_out_rdy_i);
            compare("mon_rdy_o", 0, mon_rdy_i);
        end else begin
            if (oe_i && off_in_rdy_i) begin
                protocol_error("bus driven while inbound beats are accepted");
            end
            if (off_out_vld_i && !oe_i) begin
                protocol_error("outbound beat offered with the output enable low");
            end
            // Only the port that owns the burst may raise valid
            if (ccu_vld_i && ccu_exp_q.size() == 0) begin
                protocol_error("ccu valid with no beat expected");
            end else if (ccu_vld_i && ccu_rdy_i) begin
                exp_in = ccu_exp_q.pop_front();
                compare("ccu_data_o", exp_in[`LINK_DATA_W:1], ccu_data_i);
                compare("ccu_last_o", exp_in[0], ccu_last_i);
            end
            if (gic_in_vld_i && gic_exp_q.size() == 0) begin
                protocol_error("gic valid with no beat expected");
            end else if (gic_in_vld_i && gic_in_rdy_i) begin
                exp_in = gic_exp_q.pop_front();
                compare("gic_data_o", exp_in[`LINK_DATA_W:1], gic_in_data_i);
                compare("gic_last_o", exp_in[0], gic_in_last_i);
            end
            if (off_out_vld_i && off_out_rdy_i) begin
                if (ccu_exp_q.size() + gic_exp_q.size() != 0) begin
                    protocol_error("outbound beat driven while an inbound burst is open");
                end
                if (off_exp_q.size() == 0) begin
                    protocol_error("off-chip beat with no beat expected");
                end else begin
                    exp_out = off_exp_q.pop_front();
                    compare("off_out_beat_o.data", exp_out.data, off_out_beat_i.data);
                    compare("off_out_beat_o.cmd", exp_out.cmd, off_out_beat_i.cmd);
                    compare("off_out_beat_o.last", exp_out.last, off_out_beat_i.last);
                end
            end
        end
    end

endmodule

/* tb_chip_link.sv */
// Chip link testbench that runs a table of bursts through both link directions
`include "link_defs.svh"

module tb_chip_link
    import link_pkg::*;
();

    localparam int unsigned SEED        = 32'h6a15_2582;
    localparam int          BEAT_LIMIT  = 200;
    localparam int          DRAIN_LIMIT = 400;

    // Burst kinds
    localparam logic [2:0] K_IN      = 3'd0;
    localparam logic [2:0] K_MON     = 3'd1;
    localparam logic [2:0] K_GIC     = 3'd2;
    localparam logic [2:0] K_MON_GIC = 3'd3;
    localparam logic [2:0] K_IN_MON  = 3'd4;

    // Expected targets
    localparam logic [1:0] TGT_CCU = 2'd0;
    localparam logic [1:0] TGT_GIC = 2'd1;
    localparam logic [1:0] TGT_OFF = 2'd2;

    typedef struct packed {
        logic [2:0] kind;
        logic       tag;
        logic [7:0] len;
        logic [7:0] stall;
        logic [1:0] target;
    } burst_t;

    logic clk;
    logic rst_n;
    logic off_in_vld_i, off_in_rdy_o, off_out_vld_o, off_out_rdy_i, oe_o;
    in_beat_t  off_in_beat_i;
    out_beat_t off_out_beat_o, gic_beat_i;
    logic ccu_vld_o, ccu_last_o, ccu_rdy_i, gic_vld_o, gic_last_o, gic_rdy_i;
    logic [`LINK_DATA_W-1:0] ccu_data_o, gic_data_o, mon_data_i;
    logic gic_vld_i, gic_rdy_o, mon_vld_i, mon_last_i, mon_rdy_o;

    burst_t                  bursts [16];
    int                      n_bursts;
    logic [`LINK_DATA_W-1:0] in_dat [64];
    logic [`LINK_DATA_W-1:0] mon_dat [64];
    logic [`LINK_DATA_W-1:0] gic_dat [64];
    logic                    gic_cmd [64];
    int                      cycle = 0;
    int                      stall_end = 0;
    int                      timeouts;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    chip_link_top chip_link_top_i (
        .clk(clk), .rst_n(rst_n),
        .off_in_vld_i(off_in_vld_i), .off_in_beat_i(off_in_beat_i),
        .off_in_rdy_o(off_in_rdy_o), .off_out_vld_o(off_out_vld_o),
        .off_out_beat_o(off_out_beat_o), .off_out_rdy_i(off_out_rdy_i), .oe_o(oe_o),
        .ccu_vld_o(ccu_vld_o), .ccu_data_o(ccu_data_o), .ccu_last_o(ccu_last_o),
        .ccu_rdy_i(ccu_rdy_i), .gic_vld_o(gic_vld_o), .gic_data_o(gic_data_o),
        .gic_last_o(gic_last_o), .gic_rdy_i(gic_rdy_i), .gic_vld_i(gic_vld_i),
        .gic_beat_i(gic_beat_i), .gic_rdy_o(gic_rdy_o), .mon_vld_i(mon_vld_i),
        .mon_data_i(mon_data_i), .mon_last_i(mon_last_i), .mon_rdy_o(mon_rdy_o)
    );

    link_checker link_checker_i (
        .clk(clk), .rst_n(rst_n), .off_in_rdy_i(off_in_rdy_o),
        .off_out_vld_i(off_out_vld_o), .off_out_beat_i(off_out_beat_o),
        .off_out_rdy_i(off_out_rdy_i), .oe_i(oe_o), .ccu_vld_i(ccu_vld_o),
        .ccu_data_i(ccu_data_o), .ccu_last_i(ccu_last_o), .ccu_rdy_i(ccu_rdy_i),
        .gic_in_vld_i(gic_vld_o), .gic_in_data_i(gic_data_o),
        .gic_in_last_i(gic_last_o), .gic_in_rdy_i(gic_rdy_i),
        .gic_out_rdy_i(gic_rdy_o), .mon_rdy_i(mon_rdy_o)
    );

    // ------------------------------
    // Table and expected beats
    // ------------------------------

    task automatic add_entry(input logic [2:0] kind, input logic tag, input int len,
                             input int stall, input logic [1:0] target);
        burst_t e;
        e.kind   = kind;
        e.tag    = tag;
        e.len    = len;
        e.stall  = stall;
        e.target = target;
        bursts[n_bursts] = e;
        n_bursts++;
    endtask

    task automatic fill_burst(input burst_t e);
        out_beat_t ob;
        int        i;
        for (i = 0; i < e.len; i++) begin
            in_dat[i]  = $urandom;
            mon_dat[i] = $urandom;
            gic_dat[i] = $urandom;
            gic_cmd[i] = $urandom % 2;
            if (e.kind == K_IN || e.kind == K_IN_MON) begin
                link_checker_i.expect_in(e.target == TGT_GIC, in_dat[i], i == e.len - 1);
            end
        end
        // Monitor burst leaves whole before any gic beat
        for (i = 0; i < e.len; i++) begin
            if (e.kind == K_MON || e.kind == K_MON_GIC || e.kind == K_IN_MON) begin
                ob.data = mon_dat[i];
                ob.cmd  = 1'b0;
                ob.last = (i == e.len - 1);
                link_checker_i.queue_out_beat(ob);
            end
        end
        for (i = 0; i < e.len; i++) begin
            if (e.kind == K_GIC || e.kind == K_MON_GIC) begin
                ob.data = gic_dat[i];
                ob.cmd  = gic_cmd[i];
                ob.last = (i == e.len - 1);
                link_checker_i.queue_out_beat(ob);
            end
        end
    endtask

    // ------------------------------
    // Drivers
    // ------------------------------

    task automatic drive_off_chip_in(input logic tag, input int len);
        int   i;
        int   waited;
        logic taken;
        for (i = 0; i < len && timeouts == 0; i++) begin
            @(negedge clk);
            off_in_vld_i       = 1'b1;
            off_in_beat_i.data = in_dat[i];
            off_in_beat_i.last = (i == len - 1);
            off_in_beat_i.tag  = tag;
            taken  = 1'b0;
            waited = 0;
            while (!taken && waited < BEAT_LIMIT) begin
                @(posedge clk);
                taken = off_in_rdy_o;
                waited++;
            end
            if (!taken) begin
                timeouts++;
                $display("Timeout: inbound beat %0d was never accepted off-chip", i);
            end
        end
        @(negedge clk);
        off_in_vld_i = 1'b0;
    endtask

    task automatic monitor_source(input int len);
        int   i;
        int   waited;
        logic taken;
        for (i = 0; i < len && timeouts == 0; i++) begin
            @(negedge clk);
            mon_vld_i  = 1'b1;
            mon_data_i = mon_dat[i];
            mon_last_i = (i == len - 1);
            taken  = 1'b0;
            waited = 0;
            while (!taken && waited < BEAT_LIMIT) begin
                @(posedge clk);
                taken = mon_rdy_o;
                waited++;
            end
            if (!taken) begin
                timeouts++;
                $display("Timeout: monitor beat %0d was never taken", i);
            end
        end
        @(negedge clk);
        mon_vld_i = 1'b0;
    endtask

    task automatic gic_source(input int len);
        int   i;
        int   waited;
        logic taken;
        for (i = 0; i < len && timeouts == 0; i++) begin
            @(negedge clk);
            gic_vld_i       = 1'b1;
            gic_beat_i.data = gic_dat[i];
            gic_beat_i.cmd  = gic_cmd[i];
            gic_beat_i.last = (i == len - 1);
            taken  = 1'b0;
            waited = 0;
            while (!taken && waited < BEAT_LIMIT) begin
                @(posedge clk);
                taken = gic_rdy_o;
                waited++;
            end
            if (!taken) begin
                timeouts++;
                $display("Timeout: buffer controller beat %0d was never taken", i);
            end
        end
        @(negedge clk);
        gic_vld_i = 1'b0;
    endtask

    // Random ready drops with the receivers held off during a stall window
    task automatic toggle_readies();
        forever begin
            @(negedge clk);
            ccu_rdy_i     = (cycle >= stall_end) && ($urandom % 4 != 0);
            gic_rdy_i     = (cycle >= stall_end) && ($urandom % 4 != 0);
            off_out_rdy_i = ($urandom % 4 != 0);
        end
    endtask

    task automatic wait_drained(input int idx);
        int waited;
        waited = 0;
        while (link_checker_i.pending() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (link_checker_i.pending() != 0) begin
            timeouts++;
            $display("Timeout: burst %0d was not fully delivered", idx);
        end
        repeat (3) @(negedge clk);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin : main
        int unsigned seed;
        int          n;
        int          total;
        clk           = 1'b0;
        rst_n         = 1'b0;
        off_in_vld_i  = 1'b0;
        off_in_beat_i = '0;
        off_out_rdy_i = 1'b0;
        ccu_rdy_i     = 1'b0;
        gic_rdy_i     = 1'b0;
        gic_vld_i     = 1'b0;
        gic_beat_i    = '0;
        // Idle gic beat has cmd set that a monitor beat must never pick up
        gic_beat_i.cmd = 1'b1;
        mon_vld_i     = 1'b0;
        mon_data_i    = '0;
        mon_last_i    = 1'b0;
        timeouts      = 0;
        n_bursts      = 0;
        seed          = SEED;
        seed          = $urandom(seed);

        add_entry(K_IN,      1'b1, 4,  0,  TGT_CCU);
        add_entry(K_IN,      1'b0, 5,  0,  TGT_GIC);
        add_entry(K_MON,     1'b0, 3,  0,  TGT_OFF);
        add_entry(K_GIC,     1'b0, 4,  0,  TGT_OFF);
        add_entry(K_MON_GIC, 1'b0, 3,  0,  TGT_OFF);
        add_entry(K_IN,      1'b1, 40, 50, TGT_CCU);
        add_entry(K_IN_MON,  1'b0, 6,  0,  TGT_GIC);
        add_entry(K_IN,      1'b0, 24, 40, TGT_GIC);
        add_entry(K_GIC,     1'b0, 20, 0,  TGT_OFF);

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fork
            toggle_readies();
        join_none

        for (n = 0; n < n_bursts && timeouts == 0; n++) begin
            fill_burst(bursts[n]);
            stall_end <= cycle + bursts[n].stall;
            case (bursts[n].kind)
                K_IN:      drive_off_chip_in(bursts[n].tag, bursts[n].len);
                K_MON:     monitor_source(bursts[n].len);
                K_GIC:     gic_source(bursts[n].len);
                K_MON_GIC: begin
                    fork
                        monitor_source(bursts[n].len);
                        gic_source(bursts[n].len);
                    join
                end
                K_IN_MON:  begin
                    fork
                        drive_off_chip_in(bursts[n].tag, bursts[n].len);
                        monitor_source(bursts[n].len);
                    join
                end
                default:   ;
            endcase
            if (timeouts == 0) begin
                wait_drained(n);
            end
        end

        link_checker_i.report_leftover();
        total = link_checker_i.data_errs + link_checker_i.proto_errs + timeouts;
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 link_checker_i.data_errs, link_checker_i.proto_errs, timeouts);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
link_pkg.sv
beat_fifo.sv
link_dir_fsm.sv
link_port.sv
inbound_router.sv
outbound_merger.sv
chip_link_top.sv
link_checker.sv
tb_chip_link.sv

/* Bender.yml */
package:
  name: chip_link

sources:
  - include_dirs:
      - .
    files:
      - link_pkg.sv
      - beat_fifo.sv
      - link_dir_fsm.sv
      - link_port.sv
      - inbound_router.sv
      - outbound_merger.sv
      - chip_link_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - link_checker.sv
      - tb_chip_link.sv
